/* design/fp_macros.svh */
//##################################################
// Single-precision constants: field widths,
// canonical NaN and FCLASS.S mask bit positions
//##################################################
`ifndef FP_MACROS_SVH
`define FP_MACROS_SVH

`define FP_EXP_BITS   8
`define FP_FRAC_BITS  23

// Quiet NaN with zero payload, as produced by FMIN/FMAX
`define FP_CANONICAL_NAN  32'h7fc00000

// Width of the FCLASS.S result mask
`define FP_CLASS_BITS  10

// Bit positions inside the FCLASS.S mask
`define FP_CLASS_NEG_INF        0
`define FP_CLASS_NEG_NORMAL     1
`define FP_CLASS_NEG_SUBNORMAL  2
`define FP_CLASS_NEG_ZERO       3
`define FP_CLASS_POS_ZERO       4
`define FP_CLASS_POS_SUBNORMAL  5
`define FP_CLASS_POS_NORMAL     6
`define FP_CLASS_POS_INF        7
`define FP_CLASS_SIGNALING_NAN  8
`define FP_CLASS_QUIET_NAN      9

`endif

/* design/FpTypes.sv */
//##################################################
// Shared types of the FP unit: unit select,
// sign-injection and compare opcodes, flag set
// and the single-precision field layout
//##################################################
`default_nettype none

`include "fp_macros.svh"

package FpTypes;

    // Operation group, unused encodings give zero results
    typedef enum logic [2:0] {
        FpUnitType_Move       = 3'd0,  // FMV.X.W and FMV.W.X
        FpUnitType_Classifier = 3'd1,  // FCLASS.S
        FpUnitType_Sign       = 3'd2,  // FSGNJ family
        FpUnitType_Comparator = 3'd3   // FEQ/FLT/FLE/FMIN/FMAX
    } FpUnitType;

    typedef enum logic [1:0] {
        FpSignOp_Sgnj  = 2'd0,
        FpSignOp_Sgnjn = 2'd1,
        FpSignOp_Sgnjx = 2'd2
    } FpSignOp;

    typedef enum logic [2:0] {
        FpCmpOp_Eq  = 3'd0,
        FpCmpOp_Lt  = 3'd1,
        FpCmpOp_Le  = 3'd2,
        FpCmpOp_Min = 3'd3,
        FpCmpOp_Max = 3'd4
    } FpCmpOp;

    // Same bit order as the fflags field of fcsr
    typedef struct packed {
        logic invalid;    // NV
        logic divByZero;  // DZ
        logic overflow;   // OF
        logic underflow;  // UF
        logic inexact;    // NX
    } fflags_t;

    typedef struct packed {
        logic                     sign;
        logic [`FP_EXP_BITS-1:0]  exponent;
        logic [`FP_FRAC_BITS-1:0] fraction;
    } fp32_t;

endpackage

`default_nettype wire

/* design/FpClassifier.sv */
//##################################################
// FCLASS.S decoder, one-hot ten-bit class mask
//##################################################
`timescale 1ns/1ps
`default_nettype none

`include "fp_macros.svh"

module FpClassifier import FpTypes::*; (
    input  logic [31:0]               value,
    output logic [`FP_CLASS_BITS-1:0] classMask
);

    fp32_t x;
    logic  expAllOnes;
    logic  expZero;
    logic  fracZero;

    assign x          = value;
    assign expAllOnes = (x.exponent == {`FP_EXP_BITS{1'b1}});
    assign expZero    = (x.exponent == '0);
    assign fracZero   = (x.fraction == '0);

    always_comb begin
        classMask = '0;
        if (expAllOnes && !fracZero) begin
            // MSB of the fraction separates quiet from signaling NaN
            if (x.fraction[`FP_FRAC_BITS-1])
                classMask[`FP_CLASS_QUIET_NAN] = 1'b1;
            else
                classMask[`FP_CLASS_SIGNALING_NAN] = 1'b1;
        end else if (expAllOnes) begin
            classMask[x.sign ? `FP_CLASS_NEG_INF : `FP_CLASS_POS_INF] = 1'b1;
        end else if (expZero && fracZero) begin
            classMask[x.sign ? `FP_CLASS_NEG_ZERO : `FP_CLASS_POS_ZERO] = 1'b1;
        end else if (expZero) begin
            classMask[x.sign ? `FP_CLASS_NEG_SUBNORMAL : `FP_CLASS_POS_SUBNORMAL] = 1'b1;
        end else begin
            classMask[x.sign ? `FP_CLASS_NEG_NORMAL : `FP_CLASS_POS_NORMAL] = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* design/FpSignUnit.sv */
//##################################################
// Sign injection for FSGNJ, FSGNJN and FSGNJX
//##################################################
`timescale 1ns/1ps
`default_nettype none

module FpSignUnit import FpTypes::*; (
    input  FpSignOp     op,
    input  logic [31:0] fpSrc1,
    input  logic [31:0] fpSrc2,
    output logic [31:0] fpResult
);

    fp32_t src1;
    fp32_t src2;
    logic  newSign;

    assign src1 = fpSrc1;
    assign src2 = fpSrc2;

    always_comb begin
        unique case (op)
            FpSignOp_Sgnj:  newSign = src2.sign;
            FpSignOp_Sgnjn: newSign = ~src2.sign;
            FpSignOp_Sgnjx: newSign = src1.sign ^ src2.sign;
            default:        newSign = src1.sign;  // Unused encoding keeps sign
        endcase
    end

    // Magnitude passes through untouched, NaN payloads included
    assign fpResult = {newSign, src1.exponent, src1.fraction};

endmodule

`default_nettype wire

/* design/FpComparator.sv */
//##################################################
// FEQ/FLT/FLE and FMIN/FMAX with RISC-V NaN rules
// and invalid flag generation
//##################################################
`timescale 1ns/1ps
`default_nettype none

`include "fp_macros.svh"

module FpComparator import FpTypes::*; (
    input  FpCmpOp      op,
    input  logic [31:0] fpSrc1,
    input  logic [31:0] fpSrc2,
    output logic [31:0] intResult,
    output logic [31:0] fpResult,
    output fflags_t     flags
);

    fp32_t a;
    fp32_t b;
    logic  aNan, bNan;
    logic  aSnan, bSnan;
    logic  anyNan, anySnan;
    logic  bothZero;
    logic  magLess;
    logic  totalLess;  // -0 ordered below +0
    logic  equal;
    logic  less;       // IEEE less-than, zeros equal

    assign a = fpSrc1;
    assign b = fpSrc2;

    assign aNan    = (a.exponent == {`FP_EXP_BITS{1'b1}}) && (a.fraction != '0);
    assign bNan    = (b.exponent == {`FP_EXP_BITS{1'b1}}) && (b.fraction != '0);
    assign aSnan   = aNan && !a.fraction[`FP_FRAC_BITS-1];
    assign bSnan   = bNan && !b.fraction[`FP_FRAC_BITS-1];
    assign anyNan  = aNan || bNan;
    assign anySnan = aSnan || bSnan;

    assign bothZero  = (fpSrc1[30:0] == '0) && (fpSrc2[30:0] == '0);
    assign magLess   = fpSrc1[30:0] < fpSrc2[30:0];
    assign totalLess = (a.sign != b.sign) ? a.sign :
                       (a.sign ? (fpSrc2[30:0] < fpSrc1[30:0]) : magLess);
    assign equal     = (fpSrc1 == fpSrc2) || bothZero;
    assign less      = totalLess && !bothZero;

    always_comb begin
        intResult = '0;
        fpResult  = '0;
        flags     = '0;
        unique case (op)
            FpCmpOp_Eq: begin
                intResult[0]  = equal && !anyNan;
                flags.invalid = anySnan;  // Quiet NaN compares silently
            end
            FpCmpOp_Lt: begin
                intResult[0]  = less && !anyNan;
                flags.invalid = anyNan;
            end
            FpCmpOp_Le: begin
                intResult[0]  = (less || equal) && !anyNan;
                flags.invalid = anyNan;
            end
            FpCmpOp_Min, FpCmpOp_Max: begin
                if (aNan && bNan)
                    fpResult = `FP_CANONICAL_NAN;
                else if (aNan)
                    fpResult = fpSrc2;
                else if (bNan)
                    fpResult = fpSrc1;
                else if (op == FpCmpOp_Min)
                    fpResult = totalLess ? fpSrc1 : fpSrc2;
                else
                    fpResult = totalLess ? fpSrc2 : fpSrc1;
                flags.invalid = anySnan;
            end
            default: ;  // Unused encodings give zeros
        endcase
    end

endmodule

`default_nettype wire

/* design/Fp32Unit.sv */
//##################################################
// FP operation dispatch: submodule instances,
// result select by unit and one-cycle output stage
//##################################################
`timescale 1ns/1ps
`default_nettype none

`include "fp_macros.svh"

module Fp32Unit import FpTypes::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        issue,
    input  FpUnitType   unit,
    input  FpSignOp     signOp,
    input  FpCmpOp      cmpOp,
    input  logic [31:0] intSrc,
    input  logic [31:0] fpSrc1,
    input  logic [31:0] fpSrc2,
    output logic        resultValid,
    output logic [31:0] intResult,
    output logic [31:0] fpResult,
    output logic        writeFlags,
    output fflags_t     flagsValue
);

    logic [`FP_CLASS_BITS-1:0] classMask;
    logic [31:0]               fpResultSign;
    logic [31:0]               intResultCmp;
    logic [31:0]               fpResultCmp;
    fflags_t                   flagsCmp;

    logic [31:0] nextIntResult;
    logic [31:0] nextFpResult;
    logic        nextWriteFlags;
    fflags_t     nextFlagsValue;

    FpClassifier i_FpClassifier (
        .value     (fpSrc1),
        .classMask (classMask)
    );

    FpSignUnit i_FpSignUnit (
        .op       (signOp),
        .fpSrc1   (fpSrc1),
        .fpSrc2   (fpSrc2),
        .fpResult (fpResultSign)
    );

    FpComparator i_FpComparator (
        .op        (cmpOp),
        .fpSrc1    (fpSrc1),
        .fpSrc2    (fpSrc2),
        .intResult (intResultCmp),
        .fpResult  (fpResultCmp),
        .flags     (flagsCmp)
    );

    always_comb begin
        nextIntResult  = '0;
        nextFpResult   = '0;
        nextWriteFlags = 1'b0;
        nextFlagsValue = '0;
        unique case (unit)
            FpUnitType_Move: begin
                nextIntResult = fpSrc1;  // FMV.X.W
                nextFpResult  = intSrc;  // FMV.W.X
            end
            FpUnitType_Classifier: begin
                nextIntResult = {{(32 - `FP_CLASS_BITS){1'b0}}, classMask};
            end
            FpUnitType_Sign: begin
                nextFpResult = fpResultSign;
            end
            FpUnitType_Comparator: begin
                nextIntResult  = intResultCmp;
                nextFpResult   = fpResultCmp;
                nextWriteFlags = 1'b1;
                nextFlagsValue = flagsCmp;
            end
            default: ;  // Reserved units produce nothing
        endcase
    end

    // Outputs live for one cycle only, zero otherwise
    always_ff @(posedge clk) begin
        if (reset) begin
            resultValid <= 1'b0;
            writeFlags  <= 1'b0;
            intResult   <= '0;
            fpResult    <= '0;
            flagsValue  <= '0;
        end else begin
            resultValid <= issue;
            writeFlags  <= issue && nextWriteFlags;
            intResult   <= issue ? nextIntResult : '0;
            fpResult    <= issue ? nextFpResult : '0;
            flagsValue  <= issue ? nextFlagsValue : '0;
        end
    end

endmodule

`default_nettype wire

/* design/FpFlagsCsr.sv */
//##################################################
// Accrued exception flags (fflags part of fcsr)
// with sticky update and software overwrite
//##################################################
`timescale 1ns/1ps
`default_nettype none

module FpFlagsCsr import FpTypes::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    writeFlags,    // Strobe from the FP unit
    input  fflags_t flagsValue,
    input  logic    csrWrite,      // Software write strobe
    input  fflags_t csrWriteData,
    output fflags_t fflags
);

    fflags_t accrued;
    fflags_t merged;

    // Flags are sticky, new bits only add to the old ones
    assign merged = accrued | flagsValue;

    always_ff @(posedge clk) begin
        if (reset) begin
            accrued <= '0;
        end else if (csrWrite) begin
            accrued <= csrWriteData;  // Wins over a same-edge accrual
        end else if (writeFlags) begin
            accrued <= merged;
        end
    end

    assign fflags = accrued;

endmodule

`default_nettype wire

/* design/FpSubsystem.sv */
//##################################################
// Top level: FP unit and its accrued flag register
//##################################################
`timescale 1ns/1ps
`default_nettype none

module FpSubsystem import FpTypes::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        issue,
    input  FpUnitType   unit,
    input  FpSignOp     signOp,
    input  FpCmpOp      cmpOp,
    input  logic [31:0] intSrc,
    input  logic [31:0] fpSrc1,
    input  logic [31:0] fpSrc2,
    input  logic        csrWrite,
    input  fflags_t     csrWriteData,
    output logic        resultValid,
    output logic [31:0] intResult,
    output logic [31:0] fpResult,
    output fflags_t     fflags
);

    logic    writeFlags;
    fflags_t flagsValue;

    Fp32Unit i_Fp32Unit (
        .clk         (clk),
        .reset       (reset),
        .issue       (issue),
        .unit        (unit),
        .signOp      (signOp),
        .cmpOp       (cmpOp),
        .intSrc      (intSrc),
        .fpSrc1      (fpSrc1),
        .fpSrc2      (fpSrc2),
        .resultValid (resultValid),
        .intResult   (intResult),
        .fpResult    (fpResult),
        .writeFlags  (writeFlags),
        .flagsValue  (flagsValue)
    );

    FpFlagsCsr i_FpFlagsCsr (
        .clk          (clk),
        .reset        (reset),
        .writeFlags   (writeFlags),
        .flagsValue   (flagsValue),
        .csrWrite     (csrWrite),
        .csrWriteData (csrWriteData),
        .fflags       (fflags)
    );

endmodule

`default_nettype wire

/* tb/FpSubsystem_assert.sv */
//##################################################
// Bound checks on the FP subsystem: result strobe
// timing, flag write strobe, sticky fflags
//##################################################
`timescale 1ns/1ps
`default_nettype none

module FpSubsystemAssert (
    input logic       clk,
    input logic       reset,
    input logic       issue,
    input logic       resultValid,
    input logic       writeFlags,  // Internal strobe into the flag register
    input logic       csrWrite,
    input logic [4:0] fflags
);

    validAfterIssue: assert property (@(posedge clk) disable iff (reset)
        issue |=> resultValid)
        else $error("resultValid did not follow issue by one cycle");

    validOnlyAfterIssue: assert property (@(posedge clk) disable iff (reset)
        resultValid |-> $past(issue))
        else $error("resultValid without an issue one cycle earlier");

    flagsWithValid: assert property (@(posedge clk) disable iff (reset)
        writeFlags |-> resultValid)
        else $error("writeFlags seen without resultValid");

    // Accrued bits only drop through software or reset
    flagsSticky: assert property (@(posedge clk) disable iff (reset)
        (($past(fflags) & ~fflags) != 5'b0) |-> ($past(csrWrite) || $past(reset)))
        else $error("fflags bit cleared without csrWrite or reset");

endmodule

bind FpSubsystem FpSubsystemAssert i_FpSubsystemAssert (
    .clk         (clk),
    .reset       (reset),
    .issue       (issue),
    .resultValid (resultValid),
    .writeFlags  (writeFlags),
    .csrWrite    (csrWrite),
    .fflags      (fflags)
);

`default_nettype wire

/* tb/FpSubsystemTb.sv */
//##################################################
// Testbench for the FP subsystem with a row table
// of moves, FCLASS, sign injection, compare and
// min/max, plus fflags register behavior
//##################################################
`timescale 1ns/1ps
`default_nettype none

`include "fp_macros.svh"

module FpSubsystemTb import FpTypes::*; ();

    localparam int          ValidTimeout = 8;  // Cycles allowed until resultValid
    localparam logic [31:0] One          = 32'h3f800000;
    localparam logic [31:0] MinusOne     = 32'hbf800000;
    localparam logic [31:0] Two          = 32'h40000000;
    localparam logic [31:0] MinusTwo     = 32'hc0000000;
    localparam logic [31:0] NegZero      = 32'h80000000;
    localparam logic [31:0] QNaN         = 32'h7fc00000;
    localparam logic [31:0] SNaN         = 32'h7f800001;

    typedef struct packed {
        logic [2:0]  unit;
        logic [2:0]  op;
        logic [31:0] intSrc;
        logic [31:0] src1;
        logic [31:0] src2;
        logic [31:0] expInt;
        logic [31:0] expFp;
        logic        expInv;
        logic        clearFirst;  // csrWrite of zero on the issue edge
        logic        lateWrite;   // csrWrite on the accrual edge
        logic [4:0]  lateData;
    } row_t;

    logic        clk;
    logic        reset;
    logic        issue;
    FpUnitType   unit;
    FpSignOp     signOp;
    FpCmpOp      cmpOp;
    logic [31:0] intSrc;
    logic [31:0] fpSrc1;
    logic [31:0] fpSrc2;
    logic        csrWrite;
    fflags_t     csrWriteData;
    logic        resultValid;
    logic [31:0] intResult;
    logic [31:0] fpResult;
    fflags_t     fflags;

    row_t        rows[$];
    string       names[$];
    logic        modeClear;
    logic        modeLate;
    logic [4:0]  modeLateData;
    logic [31:0] rngState;
    logic [4:0]  flagModel;  // Expected fflags contents
    logic        timedOut;
    int          errors;
    int          passed;
    int          failed;

    FpSubsystem i_FpSubsystem (
        .clk          (clk),
        .reset        (reset),
        .issue        (issue),
        .unit         (unit),
        .signOp       (signOp),
        .cmpOp        (cmpOp),
        .intSrc       (intSrc),
        .fpSrc1       (fpSrc1),
        .fpSrc2       (fpSrc2),
        .csrWrite     (csrWrite),
        .csrWriteData (csrWriteData),
        .resultValid  (resultValid),
        .intResult    (intResult),
        .fpResult     (fpResult),
        .fflags       (fflags)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] nextRandom();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    function automatic void addRow(input string name, input logic [2:0] u, input logic [2:0] op,
            input logic [31:0] iSrc, input logic [31:0] a, input logic [31:0] b,
            input logic [31:0] expInt, input logic [31:0] expFp, input logic expInv);
        row_t r;
        r = {u, op, iSrc, a, b, expInt, expFp, expInv, modeClear, modeLate, modeLateData};
        rows.push_back(r);
        names.push_back(name);
    endfunction

    // Move rows swap the random words between the register files
    function automatic void moveRow(input string name);
        logic [31:0] iSrc;
        logic [31:0] a;
        iSrc = nextRandom();
        a    = nextRandom();
        addRow(name, FpUnitType_Move, 3'd0, iSrc, a, 32'h0, a, iSrc, 1'b0);
    endfunction

    function automatic void classRow(input string name, input logic [31:0] value, input int pos);
        addRow(name, FpUnitType_Classifier, 3'd0, 32'h0, value, 32'h0, 32'd1 << pos, 32'h0, 1'b0);
    endfunction

    function automatic void signRow(input string name, input FpSignOp op,
            input logic [31:0] a, input logic [31:0] b, input logic [31:0] expFp);
        addRow(name, FpUnitType_Sign, {1'b0, op}, 32'h0, a, b, 32'h0, expFp, 1'b0);
    endfunction

    function automatic void cmpRow(input string name, input FpCmpOp op, input logic [31:0] a,
            input logic [31:0] b, input logic [31:0] expInt, input logic [31:0] expFp,
            input logic expInv);
        addRow(name, FpUnitType_Comparator, op, 32'h0, a, b, expInt, expFp, expInv);
    endfunction

    function automatic void buildTable();
        for (int i = 0; i < 4; i++)
            moveRow($sformatf("move-%0d", i));
        classRow("class-neg-inf", 32'hff800000, `FP_CLASS_NEG_INF);
        classRow("class-neg-normal", MinusOne, `FP_CLASS_NEG_NORMAL);
        classRow("class-neg-subnormal", 32'h80400000, `FP_CLASS_NEG_SUBNORMAL);
        classRow("class-neg-zero", NegZero, `FP_CLASS_NEG_ZERO);
        classRow("class-pos-zero", 32'h0, `FP_CLASS_POS_ZERO);
        classRow("class-pos-subnormal", 32'h00000001, `FP_CLASS_POS_SUBNORMAL);
        classRow("class-pos-normal", One, `FP_CLASS_POS_NORMAL);
        classRow("class-pos-inf", 32'h7f800000, `FP_CLASS_POS_INF);
        classRow("class-snan", SNaN, `FP_CLASS_SIGNALING_NAN);
        classRow("class-qnan", QNaN, `FP_CLASS_QUIET_NAN);
        signRow("sgnj", FpSignOp_Sgnj, One, MinusTwo, MinusOne);
        signRow("sgnjn", FpSignOp_Sgnjn, MinusOne, MinusTwo, One);
        signRow("sgnjx", FpSignOp_Sgnjx, MinusOne, MinusTwo, One);
        signRow("sgnjn-nan", FpSignOp_Sgnjn, 32'h7fc12345, One, 32'hffc12345);  // Payload kept
        cmpRow("eq-equal", FpCmpOp_Eq, One, One, 32'd1, 32'h0, 1'b0);
        cmpRow("eq-unequal", FpCmpOp_Eq, One, Two, 32'd0, 32'h0, 1'b0);
        cmpRow("lt-true", FpCmpOp_Lt, MinusTwo, One, 32'd1, 32'h0, 1'b0);
        cmpRow("lt-false", FpCmpOp_Lt, Two, One, 32'd0, 32'h0, 1'b0);
        cmpRow("lt-negatives", FpCmpOp_Lt, MinusTwo, MinusOne, 32'd1, 32'h0, 1'b0);
        cmpRow("le-equal", FpCmpOp_Le, One, One, 32'd1, 32'h0, 1'b0);
        cmpRow("le-false", FpCmpOp_Le, Two, One, 32'd0, 32'h0, 1'b0);
        cmpRow("eq-zeros", FpCmpOp_Eq, 32'h0, NegZero, 32'd1, 32'h0, 1'b0);
        cmpRow("lt-zeros", FpCmpOp_Lt, NegZero, 32'h0, 32'd0, 32'h0, 1'b0);
        cmpRow("le-zeros", FpCmpOp_Le, NegZero, 32'h0, 32'd1, 32'h0, 1'b0);
        cmpRow("eq-qnan", FpCmpOp_Eq, QNaN, One, 32'd0, 32'h0, 1'b0);
        cmpRow("lt-qnan", FpCmpOp_Lt, QNaN, One, 32'd0, 32'h0, 1'b1);
        cmpRow("eq-snan", FpCmpOp_Eq, SNaN, One, 32'd0, 32'h0, 1'b1);
        cmpRow("min-qnan", FpCmpOp_Min, QNaN, Two, 32'd0, Two, 1'b0);
        cmpRow("max-qnan", FpCmpOp_Max, One, QNaN, 32'd0, One, 1'b0);
        cmpRow("min-two-nan", FpCmpOp_Min, 32'h7fc12345, SNaN, 32'd0, `FP_CANONICAL_NAN, 1'b1);
        cmpRow("max-two-qnan", FpCmpOp_Max, 32'hffc00000, 32'h7fc00001, 32'd0, `FP_CANONICAL_NAN,
               1'b0);
        cmpRow("min-snan", FpCmpOp_Min, SNaN, One, 32'd0, One, 1'b1);
        cmpRow("min-zeros", FpCmpOp_Min, 32'h0, NegZero, 32'd0, NegZero, 1'b0);
        cmpRow("max-zeros", FpCmpOp_Max, NegZero, 32'h0, 32'd0, 32'h0, 1'b0);
        cmpRow("min-mixed", FpCmpOp_Min, Two, MinusOne, 32'd0, MinusOne, 1'b0);
        cmpRow("max-mixed", FpCmpOp_Max, MinusOne, Two, 32'd0, Two, 1'b0);
        cmpRow("flag-raise", FpCmpOp_Eq, SNaN, One, 32'd0, 32'h0, 1'b1);
        // Later flag rows run without the clearing write
        modeClear = 1'b0;
        moveRow("flag-hold-move");
        cmpRow("flag-hold-lt", FpCmpOp_Lt, MinusTwo, One, 32'd1, 32'h0, 1'b0);
        modeLate = 1'b1;
        moveRow("flag-clear");  // Software writes zero
        modeLate = 1'b0;
        cmpRow("flag-reraise", FpCmpOp_Le, QNaN, One, 32'd0, 32'h0, 1'b1);
        modeLate     = 1'b1;
        modeLateData = 5'b00101;
        cmpRow("flag-write-wins", FpCmpOp_Min, SNaN, One, 32'd0, One, 1'b1);
    endfunction

    task automatic applyRow(input row_t r, input string name, input int idx);
        int waitCycles;
        int rowErrors;
        waitCycles = 0;
        rowErrors  = 0;
        @(negedge clk);
        unit         = FpUnitType'(r.unit);
        signOp       = FpSignOp'(r.op[1:0]);
        cmpOp        = FpCmpOp'(r.op);
        intSrc       = r.intSrc;
        fpSrc1       = r.src1;
        fpSrc2       = r.src2;
        issue        = 1'b1;
        csrWrite     = r.clearFirst;
        csrWriteData = '0;
        @(negedge clk);
        issue        = 1'b0;
        csrWrite     = r.lateWrite;  // Lands on the accrual edge
        csrWriteData = r.lateData;
        while (!resultValid && waitCycles < ValidTimeout) begin
            @(negedge clk);
            waitCycles++;
        end
        if (!resultValid) begin
            $display("row %0d %s: timeout, resultValid never went high", idx, name);
            csrWrite = 1'b0;
            timedOut = 1'b1;
            errors++;
            failed++;
        end else begin
            assert (intResult === r.expInt) else begin
                $display("MISMATCH at %0t: %s intResult %h, expected %h",
                         $time, name, intResult, r.expInt);
                rowErrors++;
            end
            assert (fpResult === r.expFp) else begin
                $display("MISMATCH at %0t: %s fpResult %h, expected %h",
                         $time, name, fpResult, r.expFp);
                rowErrors++;
            end
            if (r.clearFirst)
                flagModel = 5'b0;
            if (r.lateWrite)
                flagModel = r.lateData;
            else
                flagModel[4] = flagModel[4] | r.expInv;
            @(negedge clk);
            csrWrite = 1'b0;
            assert (fflags === flagModel) else begin
                $display("MISMATCH at %0t: %s fflags %b, expected %b",
                         $time, name, fflags, flagModel);
                rowErrors++;
            end
            errors += rowErrors;
            if (rowErrors == 0) begin
                passed++;
                $display("row %0d %s: pass", idx, name);
            end else begin
                failed++;
                $display("row %0d %s: fail", idx, name);
            end
        end
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        issue        = 1'b0;
        unit         = FpUnitType_Move;
        signOp       = FpSignOp_Sgnj;
        cmpOp        = FpCmpOp_Eq;
        intSrc       = 32'h0;
        fpSrc1       = 32'h0;
        fpSrc2       = 32'h0;
        csrWrite     = 1'b0;
        csrWriteData = '0;
        rngState     = 32'd71029;
        flagModel    = 5'b0;
        timedOut     = 1'b0;
        errors       = 0;
        passed       = 0;
        failed       = 0;
        modeClear    = 1'b1;
        modeLate     = 1'b0;
        modeLateData = 5'b0;
        buildTable();
        repeat (5) @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            if (!timedOut)
                applyRow(rows[i], names[i], i);
        end
        $display("rows %0d, passed %0d, failed %0d, errors %0d",
                 rows.size(), passed, failed, errors);
        if (errors == 0 && !timedOut)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+design
design/FpTypes.sv
design/FpClassifier.sv
design/FpSignUnit.sv
design/FpComparator.sv
design/Fp32Unit.sv
design/FpFlagsCsr.sv
design/FpSubsystem.sv
tb/FpSubsystem_assert.sv
tb/FpSubsystemTb.sv

/* Bender.yml */
package:
  name: fp_subsystem

export_include_dirs:
  - design

sources:
  - design/FpTypes.sv
  - design/FpClassifier.sv
  - design/FpSignUnit.sv
  - design/FpComparator.sv
  - design/Fp32Unit.sv
  - design/FpFlagsCsr.sv
  - design/FpSubsystem.sv
  - target: test
    files:
      - tb/FpSubsystem_assert.sv
      - tb/FpSubsystemTb.sv
